// ==== Bender.yml ====
package:
  name: ip_eth_tx

sources:
  - files:
      - source/ip_tx_pkg.sv
      - source/byte_stream_if.sv
      - source/ip_hdr_serializer.sv
      - source/ip_tx_ctrl.sv
      - source/axis_skid_buffer.sv
      - source/ip_eth_tx.sv
  - target: simulation
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_checker.sv
      - tb/tb_ip_eth_tx.sv

// ==== filelist.f ====
source/ip_tx_pkg.sv
source/byte_stream_if.sv
source/ip_hdr_serializer.sv
source/ip_tx_ctrl.sv
source/axis_skid_buffer.sv
source/ip_eth_tx.sv
tb/tb_clock_gen.sv
tb/tb_checker.sv
tb/tb_ip_eth_tx.sv

// ==== source/axis_skid_buffer.sv ====
module axis_skid_buffer #(
    parameter int DATA_W = ip_tx_pkg::BYTE_W
) (
    input  logic              clk,
    input  logic              rst_n,
    byte_stream_if.sink       in,
    output logic [DATA_W-1:0] m_data,
    output logic              m_valid,
    output logic              m_last,
    output logic              m_user,
    input  logic              m_ready
);

    logic              ready_q;
    logic              ready_early;
    logic              m_valid_d;
    logic              tmp_valid_q, tmp_valid_d;
    logic [DATA_W-1:0] tmp_data_q;
    logic              tmp_last_q;
    logic              tmp_user_q;
    logic              load_out;
    logic              load_tmp;
    logic              tmp_to_out;

    // accept next cycle if downstream takes a byte or nothing is held
    assign ready_early = m_ready || (!tmp_valid_q && !m_valid);
    assign in.ready = ready_q;

    always_comb begin
        m_valid_d = m_valid;
        tmp_valid_d = tmp_valid_q;
        load_out = 1'b0;
        load_tmp = 1'b0;
        tmp_to_out = 1'b0;
        if (ready_q) begin
            if (m_ready || !m_valid) begin
                m_valid_d = in.valid;
                load_out = 1'b1;
            end else begin
                // output stalled, park the byte
                tmp_valid_d = in.valid;
                load_tmp = 1'b1;
            end
        end else if (m_ready) begin
            m_valid_d = tmp_valid_q;
            tmp_valid_d = 1'b0;
            tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
            m_valid <= 1'b0;
            tmp_valid_q <= 1'b0;
        end else begin
            ready_q <= ready_early;
            m_valid <= m_valid_d;
            tmp_valid_q <= tmp_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            m_data <= in.data;
            m_last <= in.last;
            m_user <= in.user;
        end else if (tmp_to_out) begin
            m_data <= tmp_data_q;
            m_last <= tmp_last_q;
            m_user <= tmp_user_q;
        end
        if (load_tmp) begin
            tmp_data_q <= in.data;
            tmp_last_q <= in.last;
            tmp_user_q <= in.user;
        end
    end

endmodule

// ==== source/byte_stream_if.sv ====
interface byte_stream_if #(
    parameter int DATA_W = ip_tx_pkg::BYTE_W
);
    logic [DATA_W-1:0] data;
    logic              valid;
    logic              ready;
    logic              last;
    logic              user;

    // byte moves when valid and ready are high on a rising edge
    modport source (
        output data, valid, last, user,
        input  ready
    );

    modport sink (
        input  data, valid, last, user,
        output ready
    );

endinterface

// ==== source/ip_eth_tx.sv ====
module ip_eth_tx #(
    parameter int DATA_W = ip_tx_pkg::BYTE_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              s_ip_hdr_valid,
    output logic              s_ip_hdr_ready,
    input  logic [47:0]       s_eth_dest_mac,
    input  logic [47:0]       s_eth_src_mac,
    input  logic [15:0]       s_eth_type,
    input  logic [5:0]        s_ip_dscp,
    input  logic [1:0]        s_ip_ecn,
    input  logic [15:0]       s_ip_length,
    input  logic [15:0]       s_ip_identification,
    input  logic [2:0]        s_ip_flags,
    input  logic [12:0]       s_ip_fragment_offset,
    input  logic [7:0]        s_ip_ttl,
    input  logic [7:0]        s_ip_protocol,
    input  logic [31:0]       s_ip_source_ip,
    input  logic [31:0]       s_ip_dest_ip,
    input  logic [DATA_W-1:0] s_ip_payload_axis_tdata,
    input  logic              s_ip_payload_axis_tvalid,
    output logic              s_ip_payload_axis_tready,
    input  logic              s_ip_payload_axis_tlast,
    input  logic              s_ip_payload_axis_tuser,
    output logic              m_eth_hdr_valid,
    input  logic              m_eth_hdr_ready,
    output logic [47:0]       m_eth_dest_mac,
    output logic [47:0]       m_eth_src_mac,
    output logic [15:0]       m_eth_type,
    output logic [DATA_W-1:0] m_eth_payload_axis_tdata,
    output logic              m_eth_payload_axis_tvalid,
    input  logic              m_eth_payload_axis_tready,
    output logic              m_eth_payload_axis_tlast,
    output logic              m_eth_payload_axis_tuser,
    output logic              busy,
    output logic              payload_length_error
);

    ip_tx_pkg::tx_hdr_t                 hdr_in;
    ip_tx_pkg::eth_hdr_t                eth_hdr;
    logic                               capture;
    logic                               hdr_advance;
    logic [ip_tx_pkg::BYTE_W-1:0]       hdr_byte;
    logic                               hdr_last;
    logic [15:0]                        payload_len;

    byte_stream_if #(.DATA_W(DATA_W)) int_s ();

    // gather the parallel header fields
    assign hdr_in.eth.dest_mac = s_eth_dest_mac;
    assign hdr_in.eth.src_mac = s_eth_src_mac;
    assign hdr_in.eth.eth_type = s_eth_type;
    assign hdr_in.dscp = s_ip_dscp;
    assign hdr_in.ecn = s_ip_ecn;
    assign hdr_in.total_length = s_ip_length;
    assign hdr_in.identification = s_ip_identification;
    assign hdr_in.flags = s_ip_flags;
    assign hdr_in.frag_offset = s_ip_fragment_offset;
    assign hdr_in.ttl = s_ip_ttl;
    assign hdr_in.protocol = s_ip_protocol;
    assign hdr_in.src_ip = s_ip_source_ip;
    assign hdr_in.dst_ip = s_ip_dest_ip;

    assign m_eth_dest_mac = eth_hdr.dest_mac;
    assign m_eth_src_mac = eth_hdr.src_mac;
    assign m_eth_type = eth_hdr.eth_type;

    ip_hdr_serializer ser_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .capture     (capture),
        .hdr_in      (hdr_in),
        .hdr_advance (hdr_advance),
        .hdr_byte    (hdr_byte),
        .hdr_last    (hdr_last),
        .payload_len (payload_len),
        .eth_hdr     (eth_hdr)
    );

    ip_tx_ctrl ctrl_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .s_hdr_valid          (s_ip_hdr_valid),
        .s_hdr_ready          (s_ip_hdr_ready),
        .m_hdr_valid          (m_eth_hdr_valid),
        .m_hdr_ready          (m_eth_hdr_ready),
        .capture              (capture),
        .hdr_advance          (hdr_advance),
        .hdr_byte             (hdr_byte),
        .hdr_last             (hdr_last),
        .payload_len          (payload_len),
        .s_data               (s_ip_payload_axis_tdata),
        .s_valid              (s_ip_payload_axis_tvalid),
        .s_last               (s_ip_payload_axis_tlast),
        .s_user               (s_ip_payload_axis_tuser),
        .s_ready              (s_ip_payload_axis_tready),
        .out                  (int_s),
        .busy                 (busy),
        .payload_length_error (payload_length_error)
    );

    axis_skid_buffer #(.DATA_W(DATA_W)) skid_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .in      (int_s),
        .m_data  (m_eth_payload_axis_tdata),
        .m_valid (m_eth_payload_axis_tvalid),
        .m_last  (m_eth_payload_axis_tlast),
        .m_user  (m_eth_payload_axis_tuser),
        .m_ready (m_eth_payload_axis_tready)
    );

endmodule

// ==== source/ip_hdr_serializer.sv ====
module ip_hdr_serializer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          capture,
    input  ip_tx_pkg::tx_hdr_t            hdr_in,
    input  logic                          hdr_advance,
    output logic [ip_tx_pkg::BYTE_W-1:0]  hdr_byte,
    output logic                          hdr_last,
    output logic [15:0]                   payload_len,
    output ip_tx_pkg::eth_hdr_t           eth_hdr
);

    localparam logic [4:0] LAST_PTR = 5'(ip_tx_pkg::IP_HDR_BYTES - 1);

    ip_tx_pkg::ipv4_hdr_u hdr_new;
    ip_tx_pkg::ipv4_hdr_u hdr_q;
    ip_tx_pkg::eth_hdr_t  eth_q;

    logic [4:0]  ptr_q;
    logic [15:0] sum_q;

    // checksum field starts at zero so it drops out of the sum
    always_comb begin
        hdr_new = '0;
        hdr_new.fields.version = ip_tx_pkg::IP_VERSION;
        hdr_new.fields.ihl = ip_tx_pkg::IP_IHL;
        hdr_new.fields.dscp = hdr_in.dscp;
        hdr_new.fields.ecn = hdr_in.ecn;
        hdr_new.fields.total_length = hdr_in.total_length;
        hdr_new.fields.identification = hdr_in.identification;
        hdr_new.fields.flags = hdr_in.flags;
        hdr_new.fields.frag_offset = hdr_in.frag_offset;
        hdr_new.fields.ttl = hdr_in.ttl;
        hdr_new.fields.protocol = hdr_in.protocol;
        hdr_new.fields.src_ip = hdr_in.src_ip;
        hdr_new.fields.dst_ip = hdr_in.dst_ip;
    end

    // header payload
    always_ff @(posedge clk) begin
        if (capture) begin
            hdr_q <= hdr_new;
            eth_q <= hdr_in.eth;
        end
    end

    // byte pointer and running checksum
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q <= '0;
            sum_q <= '0;
        end else if (capture) begin
            ptr_q <= '0;
            sum_q <= '0;
        end else if (hdr_advance) begin
            if (ptr_q < 5'd10) begin
                sum_q <= ip_tx_pkg::add_ones_complement(sum_q, hdr_q.words[ptr_q[3:0]]);
            end
            if (ptr_q != LAST_PTR) begin
                ptr_q <= ptr_q + 5'd1;
            end
        end
    end

    // words 0..9 are summed by the time byte 10 goes out
    always_comb begin
        case (ptr_q)
            5'd10:   hdr_byte = ~sum_q[15:8];
            5'd11:   hdr_byte = ~sum_q[7:0];
            default: hdr_byte = hdr_q.bytes[ptr_q];
        endcase
    end

    assign hdr_last = (ptr_q == LAST_PTR);
    assign payload_len = hdr_q.fields.total_length - 16'(ip_tx_pkg::IP_HDR_BYTES);
    assign eth_hdr = eth_q;

endmodule

// ==== source/ip_tx_ctrl.sv ====
module ip_tx_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          s_hdr_valid,
    output logic                          s_hdr_ready,
    output logic                          m_hdr_valid,
    input  logic                          m_hdr_ready,
    output logic                          capture,
    output logic                          hdr_advance,
    input  logic [ip_tx_pkg::BYTE_W-1:0]  hdr_byte,
    input  logic                          hdr_last,
    input  logic [15:0]                   payload_len,
    input  logic [ip_tx_pkg::BYTE_W-1:0]  s_data,
    input  logic                          s_valid,
    input  logic                          s_last,
    input  logic                          s_user,
    output logic                          s_ready,
    byte_stream_if.source                 out,
    output logic                          busy,
    output logic                          payload_length_error
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD
    } state_t;

    state_t      state_q, state_d;
    logic        s_hdr_ready_q, s_hdr_ready_d;
    logic        m_hdr_valid_q, m_hdr_valid_d;
    logic [15:0] word_cnt_q, word_cnt_d;
    logic        len_err_q, len_err_d;
    logic        busy_q;

    // both terms are flops, no path from s_valid or downstream ready
    assign s_ready = (state_q == ST_PAYLOAD) && out.ready;

    always_comb begin
        state_d = state_q;
        s_hdr_ready_d = 1'b0;
        m_hdr_valid_d = m_hdr_valid_q && !m_hdr_ready;
        word_cnt_d = word_cnt_q;
        len_err_d = 1'b0;
        capture = 1'b0;
        hdr_advance = 1'b0;
        out.valid = 1'b0;
        out.data = '0;
        out.last = 1'b0;
        out.user = 1'b0;

        case (state_q)
            ST_IDLE: begin
                // wait for the eth header output to drain first
                s_hdr_ready_d = !m_hdr_valid_d;
                if (s_hdr_valid && s_hdr_ready_q) begin
                    capture = 1'b1;
                    s_hdr_ready_d = 1'b0;
                    m_hdr_valid_d = 1'b1;
                    state_d = ST_HEADER;
                end
            end
            ST_HEADER: begin
                out.valid = 1'b1;
                out.data = hdr_byte;
                if (out.ready) begin
                    hdr_advance = 1'b1;
                    if (hdr_last) begin
                        word_cnt_d = payload_len;
                        state_d = ST_PAYLOAD;
                    end
                end
            end
            ST_PAYLOAD: begin
                out.data = s_data;
                out.last = s_last;
                out.user = s_user;
                if (s_valid && s_ready) begin
                    out.valid = 1'b1;
                    // saturate so an overlong payload stays flagged
                    if (word_cnt_q != 16'd0) begin
                        word_cnt_d = word_cnt_q - 16'd1;
                    end
                    if (s_last) begin
                        if (word_cnt_q != 16'd1) begin
                            out.user = 1'b1;
                            len_err_d = 1'b1;
                        end
                        s_hdr_ready_d = !m_hdr_valid_d;
                        state_d = ST_IDLE;
                    end
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            s_hdr_ready_q <= 1'b0;
            m_hdr_valid_q <= 1'b0;
            word_cnt_q <= '0;
            len_err_q <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            state_q <= state_d;
            s_hdr_ready_q <= s_hdr_ready_d;
            m_hdr_valid_q <= m_hdr_valid_d;
            word_cnt_q <= word_cnt_d;
            len_err_q <= len_err_d;
            busy_q <= (state_d != ST_IDLE);
        end
    end

    assign s_hdr_ready = s_hdr_ready_q;
    assign m_hdr_valid = m_hdr_valid_q;
    assign busy = busy_q;
    assign payload_length_error = len_err_q;

endmodule

// ==== source/ip_tx_pkg.sv ====
package ip_tx_pkg;

    localparam int BYTE_W = 8;
    localparam int IP_HDR_BYTES = 20;

    localparam logic [3:0] IP_VERSION = 4'd4;
    localparam logic [3:0] IP_IHL = 4'd5;

    // ipv4 header without options, first field in the top bits
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] total_length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] frag_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] checksum;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
    } ipv4_hdr_t;

    // byte view feeds the serializer, word view feeds the checksum
    typedef union packed {
        ipv4_hdr_t                  fields;
        logic [0:19][BYTE_W-1:0]    bytes;
        logic [0:9][15:0]           words;
    } ipv4_hdr_u;

    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    typedef struct packed {
        eth_hdr_t    eth;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] total_length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] frag_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
    } tx_hdr_t;

    // end-around carry folds bit 16 back into the sum
    function automatic logic [15:0] add_ones_complement(input logic [15:0] a,
                                                        input logic [15:0] b);
        logic [16:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[15:0] + {15'd0, sum[16]};
    endfunction

endpackage

// ==== tb/tb_checker.sv ====
module tb_checker (
    input logic        clk,
    input logic        rst_n,
    input logic        s_ip_hdr_valid,
    input logic        s_ip_hdr_ready,
    input logic [47:0] s_eth_dest_mac,
    input logic [47:0] s_eth_src_mac,
    input logic [15:0] s_eth_type,
    input logic [5:0]  s_ip_dscp,
    input logic [1:0]  s_ip_ecn,
    input logic [15:0] s_ip_length,
    input logic [15:0] s_ip_identification,
    input logic [2:0]  s_ip_flags,
    input logic [12:0] s_ip_fragment_offset,
    input logic [7:0]  s_ip_ttl,
    input logic [7:0]  s_ip_protocol,
    input logic [31:0] s_ip_source_ip,
    input logic [31:0] s_ip_dest_ip,
    input logic [7:0]  s_ip_payload_axis_tdata,
    input logic        s_ip_payload_axis_tvalid,
    input logic        s_ip_payload_axis_tready,
    input logic        s_ip_payload_axis_tlast,
    input logic        s_ip_payload_axis_tuser,
    input logic        m_eth_hdr_valid,
    input logic        m_eth_hdr_ready,
    input logic [47:0] m_eth_dest_mac,
    input logic [47:0] m_eth_src_mac,
    input logic [15:0] m_eth_type,
    input logic [7:0]  m_eth_payload_axis_tdata,
    input logic        m_eth_payload_axis_tvalid,
    input logic        m_eth_payload_axis_tready,
    input logic        m_eth_payload_axis_tlast,
    input logic        m_eth_payload_axis_tuser,
    input logic        busy,
    input logic        payload_length_error
);
    timeunit 1ns;
    timeprecision 1ps;

    // entries are {user, last, data}
    logic [9:0]  exp_q[$];
    logic [47:0] exp_dest_mac;
    logic [47:0] exp_src_mac;
    logic [15:0] exp_type;
    logic [15:0] exp_plen;
    logic [15:0] pay_cnt;
    logic        err_exp;
    // eth header accepted at the input and not yet taken at the output
    logic        eth_pend;
    logic        busy_exp;
    bit          after_reset;
    int          err_cnt;
    int          checked_cnt;
    int          pending;

    // 20 header bytes with word 0 in the top bits
    function automatic logic [159:0] ref_header(input logic [5:0] dscp, input logic [1:0] ecn,
                                                input logic [15:0] len, input logic [15:0] id,
                                                input logic [2:0] flags, input logic [12:0] frag,
                                                input logic [7:0] ttl, input logic [7:0] proto,
                                                input logic [31:0] src, input logic [31:0] dst);
        logic [0:9][15:0] w;
        logic [31:0]      acc;
        w = {4'd4, 4'd5, dscp, ecn, len, id, flags, frag, ttl, proto, 16'h0000, src, dst};
        acc = '0;
        for (int i = 0; i < 10; i++) begin
            acc = acc + 32'(w[i]);
        end
        // a single fold can carry again so fold twice
        acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
        acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
        w[5] = ~acc[15:0];
        return w;
    endfunction

    task automatic check_value(input string name, input logic [47:0] exp, input logic [47:0] got);
        if (exp !== got) begin
            $display("FAILED %s expected %0h got %0h", name, exp, got);
            err_cnt++;
        end
    endtask

    // values are stable at the falling edge
    always @(negedge clk) begin : sample
        logic [159:0] hb;
        logic [9:0]   ent;
        logic         mism;
        if (!rst_n) begin
            exp_q.delete();
            err_exp = 1'b0;
            eth_pend = 1'b0;
            busy_exp = 1'b0;
            pay_cnt = '0;
            after_reset = 1'b1;
        end else begin
            if (after_reset) begin
                check_value("s_ip_hdr_ready", 48'd0, {47'd0, s_ip_hdr_ready});
                check_value("m_eth_payload_axis_tvalid", 48'd0,
                            {47'd0, m_eth_payload_axis_tvalid});
                after_reset = 1'b0;
            end
            check_value("payload_length_error", {47'd0, err_exp}, {47'd0, payload_length_error});
            err_exp = 1'b0;
            check_value("busy", {47'd0, busy_exp}, {47'd0, busy});
            check_value("m_eth_hdr_valid", {47'd0, eth_pend}, {47'd0, m_eth_hdr_valid});

            if (m_eth_hdr_valid) begin
                check_value("m_eth_dest_mac", exp_dest_mac, m_eth_dest_mac);
                check_value("m_eth_src_mac", exp_src_mac, m_eth_src_mac);
                check_value("m_eth_type", {32'd0, exp_type}, {32'd0, m_eth_type});
            end
            if (m_eth_hdr_valid && m_eth_hdr_ready) begin
                eth_pend = 1'b0;
            end

            if (m_eth_payload_axis_tvalid && m_eth_payload_axis_tready) begin
                if (exp_q.size() == 0) begin
                    $display("output byte arrived while no byte was expected");
                    err_cnt++;
                end else begin
                    ent = exp_q.pop_front();
                    check_value("m_eth_payload_axis_tdata", {40'd0, ent[7:0]},
                                {40'd0, m_eth_payload_axis_tdata});
                    check_value("m_eth_payload_axis_tlast", {47'd0, ent[8]},
                                {47'd0, m_eth_payload_axis_tlast});
                    check_value("m_eth_payload_axis_tuser", {47'd0, ent[9]},
                                {47'd0, m_eth_payload_axis_tuser});
                    checked_cnt++;
                end
            end

            if (s_ip_hdr_valid && s_ip_hdr_ready) begin
                hb = ref_header(s_ip_dscp, s_ip_ecn, s_ip_length, s_ip_identification,
                                s_ip_flags, s_ip_fragment_offset, s_ip_ttl, s_ip_protocol,
                                s_ip_source_ip, s_ip_dest_ip);
                for (int i = 0; i < 20; i++) begin
                    exp_q.push_back({2'b00, hb[159 - 8 * i -: 8]});
                end
                exp_dest_mac = s_eth_dest_mac;
                exp_src_mac = s_eth_src_mac;
                exp_type = s_eth_type;
                exp_plen = s_ip_length - 16'd20;
                pay_cnt = '0;
                eth_pend = 1'b1;
                busy_exp = 1'b1;
            end

            if (s_ip_payload_axis_tvalid && s_ip_payload_axis_tready) begin
                pay_cnt++;
                if (s_ip_payload_axis_tlast) begin
                    // short and long payloads are flagged alike
                    mism = (pay_cnt != exp_plen);
                    exp_q.push_back({s_ip_payload_axis_tuser | mism, 1'b1,
                                     s_ip_payload_axis_tdata});
                    err_exp = mism;
                    pay_cnt = '0;
                    busy_exp = 1'b0;
                end else begin
                    exp_q.push_back({s_ip_payload_axis_tuser, 1'b0, s_ip_payload_axis_tdata});
                end
            end
            pending = exp_q.size();
        end
    end

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD_NS = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release lands just after an edge, like the other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

// ==== tb/tb_ip_eth_tx.sv ====
module tb_ip_eth_tx;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 400;
    localparam int NUM_FRAMES = 12;

    logic        clk;
    logic        rst_n;
    logic        s_ip_hdr_valid;
    logic        s_ip_hdr_ready;
    logic [47:0] s_eth_dest_mac;
    logic [47:0] s_eth_src_mac;
    logic [15:0] s_eth_type;
    logic [5:0]  s_ip_dscp;
    logic [1:0]  s_ip_ecn;
    logic [15:0] s_ip_length;
    logic [15:0] s_ip_identification;
    logic [2:0]  s_ip_flags;
    logic [12:0] s_ip_fragment_offset;
    logic [7:0]  s_ip_ttl;
    logic [7:0]  s_ip_protocol;
    logic [31:0] s_ip_source_ip;
    logic [31:0] s_ip_dest_ip;
    logic [7:0]  s_ip_payload_axis_tdata;
    logic        s_ip_payload_axis_tvalid;
    logic        s_ip_payload_axis_tready;
    logic        s_ip_payload_axis_tlast;
    logic        s_ip_payload_axis_tuser;
    logic        m_eth_hdr_valid;
    logic        m_eth_hdr_ready;
    logic [47:0] m_eth_dest_mac;
    logic [47:0] m_eth_src_mac;
    logic [15:0] m_eth_type;
    logic [7:0]  m_eth_payload_axis_tdata;
    logic        m_eth_payload_axis_tvalid;
    logic        m_eth_payload_axis_tready;
    logic        m_eth_payload_axis_tlast;
    logic        m_eth_payload_axis_tuser;
    logic        busy;
    logic        payload_length_error;

    logic [15:0] lfsr_state;
    logic        hdr_fire;
    logic        pay_fire;
    logic        rst_seen;
    int          timeout_cnt;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(5)) clk_gen_i (.clk(clk), .rst_n(rst_n));

    ip_eth_tx dut_i (.*);

    tb_checker chk_i (.*);

    // x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [47:0] take_bits(input int n);
        logic [47:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[46:0], fb};
        end
        return v;
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        timeout_cnt++;
    endtask

    // sample handshakes mid cycle and drive new inputs 2 ns after the edge
    task automatic tick();
        @(negedge clk);
        hdr_fire = s_ip_hdr_valid && s_ip_hdr_ready;
        pay_fire = s_ip_payload_axis_tvalid && s_ip_payload_axis_tready;
        rst_seen = rst_n;
        @(posedge clk);
        #2;
        m_eth_payload_axis_tready = (take_bits(2) != 48'd0);
        m_eth_hdr_ready = take_bits(1) != 48'd0;
    endtask

    // mode 0 matching length, 1 short payload, 2 long payload
    task automatic run_frame(input int mode);
        int          plen;
        int          sent;
        int          waited;
        logic [15:0] total;
        plen = 1 + int'(take_bits(5));
        if (mode == 2 && plen < 2) begin
            plen = 2;
        end
        case (mode)
            0:       total = 16'(20 + plen);
            1:       total = 16'(21 + plen + int'(take_bits(2)));
            default: total = 16'(19 + plen);
        endcase
        s_eth_dest_mac = take_bits(48);
        s_eth_src_mac = take_bits(48);
        s_eth_type = 16'h0800;
        s_ip_dscp = 6'(take_bits(6));
        s_ip_ecn = 2'(take_bits(2));
        s_ip_length = total;
        s_ip_identification = 16'(take_bits(16));
        s_ip_flags = 3'(take_bits(3));
        s_ip_fragment_offset = 13'(take_bits(13));
        s_ip_ttl = 8'(take_bits(8));
        s_ip_protocol = 8'(take_bits(8));
        s_ip_source_ip = 32'(take_bits(32));
        s_ip_dest_ip = 32'(take_bits(32));
        s_ip_hdr_valid = 1'b1;
        hdr_fire = 1'b0;
        waited = 0;
        while (!hdr_fire) begin
            if (waited == TIMEOUT) begin
                report_timeout("the header to be accepted");
                return;
            end
            tick();
            waited++;
        end
        s_ip_hdr_valid = 1'b0;

        for (sent = 0; sent < plen; sent++) begin
            if (take_bits(2) == 48'd0) begin
                s_ip_payload_axis_tvalid = 1'b0;
                tick();
            end
            s_ip_payload_axis_tvalid = 1'b1;
            s_ip_payload_axis_tdata = 8'(take_bits(8));
            s_ip_payload_axis_tlast = (sent == plen - 1);
            // inner bytes carry a random user bit
            s_ip_payload_axis_tuser = (sent != plen - 1) && (take_bits(3) == 48'd0);
            pay_fire = 1'b0;
            waited = 0;
            while (!pay_fire) begin
                if (waited == TIMEOUT) begin
                    report_timeout("a payload byte to be accepted");
                    return;
                end
                tick();
                waited++;
            end
        end
        s_ip_payload_axis_tvalid = 1'b0;
        s_ip_payload_axis_tlast = 1'b0;
        s_ip_payload_axis_tuser = 1'b0;

        waited = 0;
        while (busy) begin
            if (waited == TIMEOUT) begin
                report_timeout("busy to fall after the frame");
                return;
            end
            tick();
            waited++;
        end
    endtask

    initial begin : stimulus
        int waited;
        lfsr_state = 16'd81;
        timeout_cnt = 0;
        rst_seen = 1'b0;
        s_ip_hdr_valid = 1'b0;
        s_eth_dest_mac = '0;
        s_eth_src_mac = '0;
        s_eth_type = '0;
        s_ip_dscp = '0;
        s_ip_ecn = '0;
        s_ip_length = '0;
        s_ip_identification = '0;
        s_ip_flags = '0;
        s_ip_fragment_offset = '0;
        s_ip_ttl = '0;
        s_ip_protocol = '0;
        s_ip_source_ip = '0;
        s_ip_dest_ip = '0;
        s_ip_payload_axis_tdata = '0;
        s_ip_payload_axis_tvalid = 1'b0;
        s_ip_payload_axis_tlast = 1'b0;
        s_ip_payload_axis_tuser = 1'b0;
        m_eth_hdr_ready = 1'b0;
        m_eth_payload_axis_tready = 1'b0;

        waited = 0;
        while (!rst_seen && timeout_cnt == 0) begin
            if (waited == TIMEOUT) begin
                report_timeout("reset to be released");
            end else begin
                tick();
                waited++;
            end
        end
        waited = 0;
        while (!s_ip_hdr_ready && timeout_cnt == 0) begin
            if (waited == TIMEOUT) begin
                report_timeout("the header input to become ready after reset");
            end else begin
                tick();
                waited++;
            end
        end

        for (int f = 0; f < NUM_FRAMES && timeout_cnt == 0; f++) begin
            run_frame(f % 3);
        end

        // drain what the buffer still holds
        waited = 0;
        while ((chk_i.pending != 0 || m_eth_payload_axis_tvalid) && timeout_cnt == 0) begin
            if (waited == TIMEOUT) begin
                report_timeout("the output stream to drain");
            end else begin
                tick();
                waited++;
            end
        end

        $display("checked %0d output bytes, %0d errors, %0d timeouts",
                 chk_i.checked_cnt, chk_i.err_cnt, timeout_cnt);
        if (chk_i.err_cnt == 0 && timeout_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
